// File: hdl/ingest_pkg.sv
package ingest_pkg;

    localparam int word_w         = 16;
    localparam int fifo_depth_log = 4;    // 16 entries
    localparam int chan_n         = 4;
    localparam int chan_w         = 2;
    localparam int len_w          = 8;    // sample count minus one
    localparam int sample_w       = 15;
    localparam int sum_w          = 24;
    localparam int seq_w          = 4;    // wraps at 16

    typedef struct packed {
        logic                               tag;     // 1 for a header
        logic [chan_w-1:0]                  chan;
        logic [len_w-1:0]                   len;
        logic [word_w-1-chan_w-len_w-1:0]   rsvd;
    } hdr_view_t;

    typedef struct packed {
        logic                               tag;     // 0 for a sample
        logic signed [sample_w-1:0]         value;
    } smp_view_t;

    typedef union packed {
        hdr_view_t  hdr;
        smp_view_t  smp;
    } in_word_t;

    typedef struct packed {
        logic       tag;
        in_word_t   word;
    } dec_word_t;

    typedef struct packed {
        logic [chan_w-1:0]          chan;
        logic [len_w:0]             count;      // 1 to 256 for a complete frame
        logic signed [sum_w-1:0]    sum;
        logic                       truncated;
    } frame_close_t;

    typedef struct packed {
        frame_close_t       close;
        logic [seq_w-1:0]   seq;
    } frame_summary_t;

endpackage

// File: hdl/dc_fifo_input.sv
module dc_fifo_input #(
    parameter int DATA_BIT   = ingest_pkg::word_w,
    parameter int DATA_DEPTH = ingest_pkg::fifo_depth_log
) (
    input  logic                    rst_n,

    input  logic                    wr_clk,
    input  logic [DATA_BIT-1:0]     wr_data,
    input  logic                    wr_en,
    output logic [DATA_DEPTH-1:0]   wr_cnt,

    input  logic                    rd_clk,
    output logic [DATA_BIT-1:0]     rd_data,
    input  logic                    rd_en,
    output logic [DATA_DEPTH-1:0]   rd_cnt,

    output logic                    empty,
    output logic                    full
);

    logic [DATA_BIT-1:0]    mem [2**DATA_DEPTH];

    logic [DATA_DEPTH:0]    w_ptr;          // binary, extra wrap bit on top
    logic [DATA_DEPTH:0]    w_gray;
    logic [DATA_DEPTH:0]    w_gray_s1;      // write pointer seen on rd_clk
    logic [DATA_DEPTH:0]    w_gray_s2;
    logic [DATA_DEPTH:0]    w_bin_rd;
    logic                   wr_push;

    logic [DATA_DEPTH:0]    r_ptr;
    logic [DATA_DEPTH:0]    r_gray;
    logic [DATA_DEPTH:0]    r_gray_s1;      // read pointer seen on wr_clk
    logic [DATA_DEPTH:0]    r_gray_s2;
    logic [DATA_DEPTH:0]    r_bin_wr;
    logic                   rd_pop;

    function automatic logic [DATA_DEPTH:0] gray2bin(input logic [DATA_DEPTH:0] g);
        logic [DATA_DEPTH:0] b;
        b[DATA_DEPTH] = g[DATA_DEPTH];
        for (int k = DATA_DEPTH - 1; k >= 0; k--) begin
            b[k] = b[k+1] ^ g[k];
        end
        return b;
    endfunction

    assign w_gray = (w_ptr >> 1) ^ w_ptr;
    assign r_gray = (r_ptr >> 1) ^ r_ptr;

    // full when the write side has lapped the read side by one whole buffer
    assign full = (w_gray[DATA_DEPTH:DATA_DEPTH-1] == ~r_gray_s2[DATA_DEPTH:DATA_DEPTH-1])
               && (w_gray[DATA_DEPTH-2:0] == r_gray_s2[DATA_DEPTH-2:0]);
    assign empty = (r_gray == w_gray_s2);

    assign wr_push = wr_en & ~full;      // offered words are dropped while full
    assign rd_pop  = rd_en & ~empty;

    assign rd_data = mem[r_ptr[DATA_DEPTH-1:0]];    // read side sees the head word directly

    assign r_bin_wr = gray2bin(r_gray_s2);
    assign w_bin_rd = gray2bin(w_gray_s2);

    always_ff @(posedge wr_clk) begin
        if (wr_push) begin
            mem[w_ptr[DATA_DEPTH-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            w_ptr <= '0;
        end else if (wr_push) begin
            w_ptr <= w_ptr + 1'b1;
        end
    end

    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            r_gray_s1 <= '0;
            r_gray_s2 <= '0;
        end else begin
            r_gray_s1 <= r_gray;
            r_gray_s2 <= r_gray_s1;
        end
    end

    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_cnt <= '0;
        end else begin
            wr_cnt <= w_ptr[DATA_DEPTH-1:0] - r_bin_wr[DATA_DEPTH-1:0];   // reads 0 when full
        end
    end

    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            r_ptr <= '0;
        end else if (rd_pop) begin
            r_ptr <= r_ptr + 1'b1;
        end
    end

    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            w_gray_s1 <= '0;
            w_gray_s2 <= '0;
        end else begin
            w_gray_s1 <= w_gray;
            w_gray_s2 <= w_gray_s1;
        end
    end

    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_cnt <= '0;
        end else begin
            rd_cnt <= w_bin_rd[DATA_DEPTH-1:0] - r_ptr[DATA_DEPTH-1:0];
        end
    end

    a_no_push_when_full: assert property (
        @(posedge wr_clk) disable iff (!rst_n)
        (DATA_DEPTH+1)'(w_ptr - r_bin_wr) <= 2**DATA_DEPTH
    ) else $error("write pointer ran more than one buffer ahead of the read pointer");

    a_no_pop_when_empty: assert property (
        @(posedge rd_clk) disable iff (!rst_n)
        (DATA_DEPTH+1)'(w_bin_rd - r_ptr) <= 2**DATA_DEPTH
    ) else $error("read pointer overtook the write pointer");

endmodule

// File: hdl/frame_decode.sv
module frame_decode (
    input  logic                    rd_clk,
    input  logic                    rst_n,
    input  logic                    hold,
    input  logic                    empty,
    input  ingest_pkg::in_word_t    rd_data,
    output logic                    rd_en,
    output logic                    dec_valid,
    output ingest_pkg::dec_word_t   dec_word
);

    logic word_tag;

    // pop whenever a word is waiting and downstream is not holding us off
    assign rd_en = ~empty & ~hold;

    // both views keep the tag in the top bit, so either one can be read here
    assign word_tag = rd_data.hdr.tag;

    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= rd_en;                 // strobe one cycle after the pop
        end
    end

    always_ff @(posedge rd_clk) begin
        if (rd_en) begin
            dec_word.tag  <= word_tag;
            dec_word.word <= rd_data;
        end
    end

    // a waiting word stays available until it is popped
    a_word_held_until_pop: assert property (
        @(posedge rd_clk) disable iff (!rst_n)
        !empty && !rd_en |=> !empty
    ) else $error("FIFO went empty without a pop");

endmodule

// File: hdl/frame_accumulate.sv
module frame_accumulate (
    input  logic                        rd_clk,
    input  logic                        rst_n,
    input  logic                        dec_valid,
    input  ingest_pkg::dec_word_t       dec_word,
    output logic                        close_valid,
    output ingest_pkg::frame_close_t    close_info
);

    import ingest_pkg::*;

    logic                       frm_open;
    logic [chan_w-1:0]          frm_chan;
    logic [len_w-1:0]           frm_len;        // declared length field of the open frame
    logic [len_w-1:0]           frm_left;       // samples still expected after the next one
    logic [len_w:0]             frm_rcv;
    logic signed [sum_w-1:0]    frm_sum;

    logic                       is_hdr;
    logic                       is_smp;
    logic                       last_smp;
    logic                       trunc_close;
    logic signed [sum_w-1:0]    smp_ext;
    logic signed [sum_w-1:0]    sum_next;

    assign is_hdr      = dec_valid & dec_word.tag;
    assign is_smp      = dec_valid & ~dec_word.tag & frm_open;   // stray samples fall out here
    assign last_smp    = is_smp & (frm_left == '0);
    assign trunc_close = is_hdr & frm_open;                      // new header cuts the frame short

    assign smp_ext  = {{(sum_w-sample_w){dec_word.word.smp.value[sample_w-1]}},
                       dec_word.word.smp.value};
    assign sum_next = frm_sum + smp_ext;

    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            frm_open    <= 1'b0;
            frm_left    <= '0;
            frm_rcv     <= '0;
            close_valid <= 1'b0;
        end else begin
            close_valid <= trunc_close | last_smp;
            if (is_hdr) begin
                frm_open <= 1'b1;
                frm_left <= dec_word.word.hdr.len;
                frm_rcv  <= '0;
            end else if (is_smp) begin
                frm_rcv  <= frm_rcv + 1'b1;
                frm_left <= frm_left - 1'b1;
                if (last_smp) begin
                    frm_open <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge rd_clk) begin
        if (is_hdr) begin
            frm_chan <= dec_word.word.hdr.chan;
            frm_len  <= dec_word.word.hdr.len;
            frm_sum  <= '0;
        end else if (is_smp) begin
            frm_sum  <= sum_next;
        end

        if (trunc_close) begin
            close_info.chan      <= frm_chan;
            close_info.count     <= frm_rcv;            // samples seen before the cut
            close_info.sum       <= frm_sum;
            close_info.truncated <= 1'b1;
        end else if (last_smp) begin
            close_info.chan      <= frm_chan;
            close_info.count     <= frm_rcv + 1'b1;
            close_info.sum       <= sum_next;
            close_info.truncated <= 1'b0;
        end
    end

    a_rcv_within_len: assert property (
        @(posedge rd_clk) disable iff (!rst_n)
        frm_open |-> (frm_rcv <= {1'b0, frm_len})
    ) else $error("received more samples than the header declared");

endmodule

// File: hdl/frame_report.sv
module frame_report (
    input  logic                        rd_clk,
    input  logic                        rst_n,
    input  logic                        close_valid,
    input  ingest_pkg::frame_close_t    close_info,
    output logic                        rpt_valid,
    output ingest_pkg::frame_summary_t  rpt_summary
);

    import ingest_pkg::*;

    logic [seq_w-1:0] seq_cnt [chan_n];     // next sequence number per channel
    logic [seq_w-1:0] seq_cur;

    assign seq_cur = seq_cnt[close_info.chan];

    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            rpt_valid <= 1'b0;
            for (int c = 0; c < chan_n; c++) begin
                seq_cnt[c] <= '0;
            end
        end else begin
            rpt_valid <= close_valid;
            if (close_valid) begin
                seq_cnt[close_info.chan] <= seq_cur + 1'b1;     // wraps naturally
            end
        end
    end

    always_ff @(posedge rd_clk) begin
        if (close_valid) begin
            rpt_summary.close <= close_info;
            rpt_summary.seq   <= seq_cur;
        end
    end

endmodule

// File: hdl/ingest_top.sv
module ingest_top (
    input  logic                        wr_clk,
    input  logic                        rd_clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    input  ingest_pkg::in_word_t        in_word,
    output logic                        full,
    input  logic                        hold,
    output logic                        rpt_valid,
    output ingest_pkg::frame_summary_t  rpt_summary
);

    import ingest_pkg::*;

    in_word_t       fifo_rd_data;
    logic           fifo_empty;
    logic           fifo_rd_en;
    logic           dec_valid;
    dec_word_t      dec_word;
    logic           close_valid;
    frame_close_t   close_info;

    dc_fifo_input #(
        .DATA_BIT   (word_w),
        .DATA_DEPTH (fifo_depth_log)
    ) i_fifo (
        .rst_n   (rst_n),
        .wr_clk  (wr_clk),
        .wr_data (in_word),
        .wr_en   (in_valid),
        .wr_cnt  (),                    // wraps to zero when full
        .rd_clk  (rd_clk),
        .rd_data (fifo_rd_data),
        .rd_en   (fifo_rd_en),
        .rd_cnt  (),
        .empty   (fifo_empty),
        .full    (full)
    );

    frame_decode i_decode (
        .rd_clk    (rd_clk),
        .rst_n     (rst_n),
        .hold      (hold),
        .empty     (fifo_empty),
        .rd_data   (fifo_rd_data),
        .rd_en     (fifo_rd_en),
        .dec_valid (dec_valid),
        .dec_word  (dec_word)
    );

    frame_accumulate i_accumulate (
        .rd_clk      (rd_clk),
        .rst_n       (rst_n),
        .dec_valid   (dec_valid),
        .dec_word    (dec_word),
        .close_valid (close_valid),
        .close_info  (close_info)
    );

    frame_report i_report (
        .rd_clk      (rd_clk),
        .rst_n       (rst_n),
        .close_valid (close_valid),
        .close_info  (close_info),
        .rpt_valid   (rpt_valid),
        .rpt_summary (rpt_summary)
    );

endmodule

// File: sim/tb_ingest.sv
module tb_ingest;

    import ingest_pkg::*;

    localparam int wr_half    = 50;
    localparam int rd_half    = 35;
    localparam int stim_words = 40 * 33 + (6 * 17) + (5 + 9) + 24 + (21 * 5);   // worst case
    localparam int wd_cycles  = stim_words * 20 + 1000;

    logic           wr_clk;
    logic           rd_clk;
    logic           rst_n;
    logic           in_valid;
    in_word_t       in_word;
    logic           full;
    logic           hold;
    logic           rpt_valid;
    frame_summary_t rpt_summary;

    in_word_t       acc_q [$];         // accepted words not yet walked by the model
    frame_summary_t exp_q [$];
    int             acc_cnt;
    int             drop_cnt;
    logic           full_seen;
    int             rpt_cnt;
    int             val_err;
    int             other_err;

    logic              m_open;          // reference model state
    logic [chan_w-1:0] m_chan;
    int                m_len;
    int                m_rcv;
    int                m_sum;
    logic [seq_w-1:0]  m_seq [chan_n];

    ingest_top i_dut (
        .wr_clk      (wr_clk),
        .rd_clk      (rd_clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_word     (in_word),
        .full        (full),
        .hold        (hold),
        .rpt_valid   (rpt_valid),
        .rpt_summary (rpt_summary)
    );

    initial begin
        wr_clk = 1'b0;
        forever #(wr_half) wr_clk = ~wr_clk;
    end

    initial begin
        rd_clk = 1'b0;
        forever #(rd_half) rd_clk = ~rd_clk;
    end

    function automatic void expect_close(input logic trunc);
        frame_summary_t s;
        s.close.chan      = m_chan;
        s.close.count     = (len_w+1)'(m_rcv);
        s.close.sum       = sum_w'(m_sum);
        s.close.truncated = trunc;
        s.seq             = m_seq[m_chan];
        m_seq[m_chan]     = m_seq[m_chan] + 1'b1;     // 4-bit wrap
        exp_q.push_back(s);
    endfunction

    // applies the frame rules to every accepted word in arrival order
    function automatic void ref_walk();
        in_word_t w;
        while (acc_q.size() != 0) begin
            w = acc_q.pop_front();
            if (w.hdr.tag) begin
                if (m_open) begin
                    expect_close(1'b1);                 // early header cuts the frame
                end
                m_open = 1'b1;
                m_chan = w.hdr.chan;
                m_len  = int'(w.hdr.len) + 1;
                m_rcv  = 0;
                m_sum  = 0;
            end else if (m_open) begin
                m_sum = m_sum + int'($signed(w.smp.value));
                m_rcv = m_rcv + 1;
                if (m_rcv == m_len) begin
                    expect_close(1'b0);
                    m_open = 1'b0;
                end
            end
        end
    endfunction

    function automatic in_word_t make_header(input int chan, input int nsamp);
        in_word_t w;
        w.hdr.tag  = 1'b1;
        w.hdr.chan = chan_w'(chan);
        w.hdr.len  = len_w'(nsamp - 1);
        w.hdr.rsvd = '0;
        return w;
    endfunction

    function automatic in_word_t make_sample();
        in_word_t w;
        w.smp.tag   = 1'b0;
        w.smp.value = sample_w'($urandom);
        return w;
    endfunction

    task automatic send_word(input in_word_t w, input int gap);
        @(negedge wr_clk);
        in_valid = 1'b1;
        in_word  = w;
        repeat (gap) begin
            @(negedge wr_clk);
            in_valid = 1'b0;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge wr_clk);
            in_valid = 1'b0;
        end
    endtask

    // nsend below nsamp leaves the frame open for the next header to truncate
    task automatic send_frame(input int chan, input int nsamp, input int nsend, input int gap_max);
        send_word(make_header(chan, nsamp), $urandom % (gap_max + 1));
        for (int i = 0; i < nsend; i++) begin
            send_word(make_sample(), $urandom % (gap_max + 1));
        end
    endtask

    task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got == exp) else begin
            $display("FAIL %s: got 0x%0h expected 0x%0h", name, got, exp);
            val_err++;
        end
    endtask

    task automatic check_report(input frame_summary_t got);
        frame_summary_t exp_s;
        rpt_cnt++;
        assert (exp_q.size() != 0) else begin
            $display("summary on channel %0d arrived while no frame was expected", got.close.chan);
            other_err++;
        end
        if (exp_q.size() != 0) begin
            exp_s = exp_q.pop_front();
            check_field("rpt_summary.close.chan", 32'(got.close.chan), 32'(exp_s.close.chan));
            check_field("rpt_summary.close.count", 32'(got.close.count), 32'(exp_s.close.count));
            check_field("rpt_summary.close.sum", 32'(got.close.sum), 32'(exp_s.close.sum));
            check_field("rpt_summary.close.truncated", 32'(got.close.truncated),
                        32'(exp_s.close.truncated));
            check_field("rpt_summary.seq", 32'(got.seq), 32'(exp_s.seq));
        end
    endtask

    task automatic wait_drain(input string phase);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 2000) begin
            @(negedge rd_clk);
            n++;
        end
        assert (exp_q.size() == 0) else begin
            $display("%0d expected summaries never arrived after %s", exp_q.size(), phase);
            other_err++;
        end
    endtask

    always @(posedge wr_clk) begin
        if (rst_n) begin
            if (full) begin
                full_seen = 1'b1;
            end
            if (in_valid && full) begin
                drop_cnt++;
            end else if (in_valid) begin
                acc_q.push_back(in_word);
                acc_cnt++;
                ref_walk();
            end
        end
    end

    always @(negedge rd_clk) begin
        if (rst_n && rpt_valid) begin
            check_report(rpt_summary);
        end
    end

    initial begin : watchdog
        #(wd_cycles * 2 * wr_half);
        $display("watchdog expired before the stimulus and reports completed");
        $display("Test failures found");
        $finish;
    end

    initial begin : stimulus
        int n;
        int acc_before;
        int drop_before;
        void'($urandom(45));
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_word = '0;
        hold = 1'b0;
        acc_cnt = 0;
        drop_cnt = 0;
        full_seen = 1'b0;
        rpt_cnt = 0;
        val_err = 0;
        other_err = 0;
        m_open = 1'b0;
        m_chan = '0;
        m_len = 0;
        m_rcv = 0;
        m_sum = 0;
        for (int c = 0; c < chan_n; c++) begin
            m_seq[c] = '0;
        end
        repeat (5) @(negedge wr_clk);
        rst_n = 1'b1;

        repeat (20) begin                           // quiet outputs with no writes
            @(negedge wr_clk);
            check_field("rpt_valid", 32'(rpt_valid), 32'd0);
            check_field("full", 32'(full), 32'd0);
        end

        for (int f = 0; f < 40; f++) begin
            n = 1 + $urandom % 32;
            send_frame($urandom % chan_n, n, n, 3);
        end
        idle(1);
        wait_drain("complete frames");

        for (int f = 0; f < 5; f++) begin
            n = 8 + $urandom % 9;
            send_frame($urandom % chan_n, n, $urandom % n, 2);
        end
        n = 1 + $urandom % 8;
        send_frame($urandom % chan_n, n, n, 2);     // closes the last cut frame cleanly

        for (int i = 0; i < 5; i++) begin
            send_word(make_sample(), $urandom % 3);  // stray, no frame open
        end
        n = 1 + $urandom % 8;
        send_frame($urandom % chan_n, n, n, 2);
        idle(1);
        wait_drain("truncated and stray words");
        idle(4);                                    // let full see the last reads

        acc_before  = acc_cnt;
        drop_before = drop_cnt;
        full_seen   = 1'b0;
        hold        = 1'b1;
        send_frame(1, 10, 10, 0);
        send_frame(2, 12, 12, 0);
        idle(2);
        assert (full_seen) else begin
            $display("full never rose while the FIFO was held");
            other_err++;
        end
        check_field("accepted words", 32'(acc_cnt - acc_before), 32'(2 ** fifo_depth_log));
        check_field("dropped words", 32'(drop_cnt - drop_before), 32'(24 - 2 ** fifo_depth_log));
        hold = 1'b0;
        idle(1);
        wait_drain("overflow");

        for (int f = 0; f < 20; f++) begin
            n = 1 + $urandom % 4;
            send_frame(3, n, n, 1);
        end
        send_frame(0, 3, 3, 1);                     // channel 0 count must be untouched by the wrap
        idle(1);
        wait_drain("sequence wrap");

        $display("summaries checked: %0d, value errors: %0d, other errors: %0d",
                 rpt_cnt, val_err, other_err);
        if (val_err == 0 && other_err == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: files.f
hdl/ingest_pkg.sv
hdl/dc_fifo_input.sv
hdl/frame_decode.sv
hdl/frame_accumulate.sv
hdl/frame_report.sv
hdl/ingest_top.sv
sim/tb_ingest.sv

// File: Makefile
TOP = tb_ingest

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f files.f
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q 'All tests passed!'

clean:
	rm -rf obj_dir
